//--- hw/pipe_stage.sv
`timescale 1ns/1ps

module pipe_stage #(
	parameter type payload_t = logic
) (
	input logic read_clk,
	input logic rst_n,

	// Upstream side
	input logic in_valid,
	output logic in_ready,
	input payload_t in_data,

	// Downstream side
	input logic out_ready,
	output logic out_valid,
	output payload_t out_data
);

	logic load;

	// Free slot or the held item leaves this cycle
	assign in_ready = !out_valid || out_ready;
	assign load = in_valid && in_ready;

	// Valid flag
	always_ff @(posedge read_clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	// Payload only moves on an accepted transfer
	always_ff @(posedge read_clk) begin
		if (load) begin
			out_data <= in_data;
		end
	end

endmodule

//--- hw/sym_vn_lut_top.sv
`timescale 1ns/1ps

module sym_vn_lut_top (
	input logic read_clk,
	input logic rst_n,

	// Lookup requests
	input logic req_valid,
	output logic req_ready,
	input vn_lut_pkg::vn_req_t req,

	// Table load, no handshake
	input logic wr_en,
	input vn_lut_pkg::lut_wr_t wr,

	// Lookup responses
	output logic rsp_valid,
	input logic rsp_ready,
	output vn_lut_pkg::vn_rsp_t rsp
);

	////////////////////////////////////////////////////////////
	// Stage 0 to stage 1 handshake
	////////////////////////////////////////////////////////////

	logic addr_valid;
	logic addr_ready;
	vn_lut_pkg::vn_addr_t addr;

	// Fold and address mapping
	vn_input_fold u_fold (
		.read_clk(read_clk),
		.rst_n(rst_n),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req(req),
		.addr_valid(addr_valid),
		.addr_ready(addr_ready),
		.addr(addr)
	);

	// Table read and response register
	vn_lut_bank u_bank (
		.read_clk(read_clk),
		.rst_n(rst_n),
		.addr_valid(addr_valid),
		.addr_ready(addr_ready),
		.addr(addr),
		.wr_en(wr_en),
		.wr(wr),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.rsp(rsp)
	);

endmodule

//--- hw/vn_input_fold.sv
`timescale 1ns/1ps

module vn_input_fold (
	input logic read_clk,
	input logic rst_n,

	// Request in
	input logic req_valid,
	output logic req_ready,
	input vn_lut_pkg::vn_req_t req,

	// Folded address out
	output logic addr_valid,
	input logic addr_ready,
	output vn_lut_pkg::vn_addr_t addr
);

	////////////////////////////////////////////////////////////
	// Sign folding
	////////////////////////////////////////////////////////////

	// Sign of y0, flipped when the port asks for a transpose
	function automatic logic port_msb(input vn_lut_pkg::vn_port_req_t p);
		return p.y0[3] ^ p.transpose_en;
	endfunction

	// Map a message pair onto the lower half of the table
	function automatic vn_lut_pkg::lut_addr_t port_addr(
		input vn_lut_pkg::vn_port_req_t p
	);
		logic [2:0] y0_fold;
		vn_lut_pkg::msg_t y1_fold;
		vn_lut_pkg::lut_addr_t a;

		// Negative y0 mirrors the magnitude code
		y0_fold = p.y0[2:0] ^ {3{p.y0[3]}};

		// y1 follows msb, all four bits
		if (port_msb(p)) begin
			y1_fold = ~p.y1;
		end else begin
			y1_fold = p.y1;
		end

		a.bank = y0_fold[2];
		a.page = {y0_fold[1:0], y1_fold};
		return a;
	endfunction

	////////////////////////////////////////////////////////////
	// Address forming for both ports
	////////////////////////////////////////////////////////////

	vn_lut_pkg::vn_addr_t fold_d;

	always_comb begin
		fold_d.addr_a = port_addr(req.port_a);
		fold_d.addr_b = port_addr(req.port_b);
		fold_d.msb_a = port_msb(req.port_a);
		fold_d.msb_b = port_msb(req.port_b);
		fold_d.offset = req.offset;
	end

	// Stage 0 register
	pipe_stage #(
		.payload_t(vn_lut_pkg::vn_addr_t)
	) u_fold_stage (
		.read_clk(read_clk),
		.rst_n(rst_n),
		.in_valid(req_valid),
		.in_ready(req_ready),
		.in_data(fold_d),
		.out_valid(addr_valid),
		.out_ready(addr_ready),
		.out_data(addr)
	);

endmodule

//--- hw/vn_lut_bank.sv
`timescale 1ns/1ps

module vn_lut_bank (
	input logic read_clk,
	input logic rst_n,

	// Folded address in
	input logic addr_valid,
	output logic addr_ready,
	input vn_lut_pkg::vn_addr_t addr,

	// Table load
	input logic wr_en,
	input vn_lut_pkg::lut_wr_t wr,

	// Lookup result out
	output logic rsp_valid,
	input logic rsp_ready,
	output vn_lut_pkg::vn_rsp_t rsp
);

	// Offset bit on top of the page
	localparam int idx_w = vn_lut_pkg::page_w + 1;
	localparam int depth = 2 ** idx_w;

	////////////////////////////////////////////////////////////
	// Table storage
	////////////////////////////////////////////////////////////

	vn_lut_pkg::msg_t bank0_mem [depth];
	vn_lut_pkg::msg_t bank1_mem [depth];

	logic [idx_w-1:0] wr_idx;

	assign wr_idx = {wr.offset, wr.page};

	// Both banks take their entry on the same write
	always_ff @(posedge read_clk) begin
		if (wr_en) begin
			bank0_mem[wr_idx] <= wr.data_bank0;
			bank1_mem[wr_idx] <= wr.data_bank1;
		end
	end

	////////////////////////////////////////////////////////////
	// Read ports
	////////////////////////////////////////////////////////////

	logic [idx_w-1:0] idx_a;
	logic [idx_w-1:0] idx_b;
	vn_lut_pkg::msg_t rd_a;
	vn_lut_pkg::msg_t rd_b;

	// Offset is shared by both ports
	assign idx_a = {addr.offset, addr.addr_a.page};
	assign idx_b = {addr.offset, addr.addr_b.page};

	// Bank select per port
	always_comb begin
		if (addr.addr_a.bank) begin
			rd_a = bank1_mem[idx_a];
		end else begin
			rd_a = bank0_mem[idx_a];
		end
		if (addr.addr_b.bank) begin
			rd_b = bank1_mem[idx_b];
		end else begin
			rd_b = bank0_mem[idx_b];
		end
	end

	vn_lut_pkg::vn_rsp_t rsp_d;

	always_comb begin
		rsp_d.t_c_a = rd_a;
		rsp_d.t_c_b = rd_b;
		// msb becomes the transpose control of the next node
		rsp_d.transpose_en_a = addr.msb_a;
		rsp_d.transpose_en_b = addr.msb_b;
		rsp_d.offset = addr.offset;
	end

	// Stage 1 register
	pipe_stage #(
		.payload_t(vn_lut_pkg::vn_rsp_t)
	) u_rsp_stage (
		.read_clk(read_clk),
		.rst_n(rst_n),
		.in_valid(addr_valid),
		.in_ready(addr_ready),
		.in_data(rsp_d),
		.out_valid(rsp_valid),
		.out_ready(rsp_ready),
		.out_data(rsp)
	);

endmodule

//--- hw/vn_lut_pkg.sv
package vn_lut_pkg;

	////////////////////////////////////////////////////////////
	// Table format widths
	////////////////////////////////////////////////////////////

	// Incoming and outgoing message width
	localparam int msg_w = 4;

	// Page address within one bank half
	localparam int page_w = 6;

	// Bit 3 is the sign, bits 2..0 the magnitude code
	typedef logic [msg_w-1:0] msg_t;

	////////////////////////////////////////////////////////////
	// Request side
	////////////////////////////////////////////////////////////

	// One read port, message pair plus transpose control
	typedef struct packed {
		msg_t y0;
		msg_t y1;
		logic transpose_en;
	} vn_port_req_t;

	// Offset selects the table half for both ports
	typedef struct packed {
		vn_port_req_t port_a;
		vn_port_req_t port_b;
		logic offset;
	} vn_req_t;

	////////////////////////////////////////////////////////////
	// Internal and response side
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic bank;
		logic [page_w-1:0] page;
	} lut_addr_t;

	// Stage 0 result, the folded addresses and the sign bits
	typedef struct packed {
		lut_addr_t addr_a;
		lut_addr_t addr_b;
		logic msb_a;
		logic msb_b;
		logic offset;
	} vn_addr_t;

	typedef struct packed {
		msg_t t_c_a;
		msg_t t_c_b;
		logic transpose_en_a;
		logic transpose_en_b;
		logic offset;
	} vn_rsp_t;

	// Table load from the decoder, one entry in each bank
	typedef struct packed {
		msg_t data_bank0;
		msg_t data_bank1;
		logic [page_w-1:0] page;
		logic offset;
	} lut_wr_t;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module sym_vn_lut_tb \
	-f verilog.f \
	-o sim_vn_lut

./obj_dir/sim_vn_lut | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	echo "Simulation reported failures"
	exit 1
fi

echo "Simulation finished without failures"

//--- verification/sym_vn_lut_props.sv
`timescale 1ns/1ps

module sym_vn_lut_props (
	input logic read_clk,
	input logic rst_n,
	input logic addr_valid,
	input logic addr_ready,
	input vn_lut_pkg::vn_addr_t addr,
	input logic rsp_valid,
	input logic rsp_ready,
	input vn_lut_pkg::vn_rsp_t rsp
);

	////////////////////////////////////////////////////////////
	// Handshake stability under back-pressure
	////////////////////////////////////////////////////////////

	rsp_hold: assert property (@(posedge read_clk) disable iff (!rst_n)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
		else $error("rsp dropped or changed while stalled");

	// Internal stage 0 to stage 1 link
	addr_hold: assert property (@(posedge read_clk) disable iff (!rst_n)
		addr_valid && !addr_ready |=> addr_valid && $stable(addr))
		else $error("addr dropped or changed while stalled");

	////////////////////////////////////////////////////////////
	// Reset
	////////////////////////////////////////////////////////////

	rsp_reset: assert property (@(posedge read_clk) !rst_n |=> !rsp_valid)
		else $error("rsp_valid high after reset");

	addr_reset: assert property (@(posedge read_clk) !rst_n |=> !addr_valid)
		else $error("addr_valid high after reset");

endmodule

bind sym_vn_lut_top sym_vn_lut_props u_props (
	.read_clk(read_clk),
	.rst_n(rst_n),
	.addr_valid(addr_valid),
	.addr_ready(addr_ready),
	.addr(addr),
	.rsp_valid(rsp_valid),
	.rsp_ready(rsp_ready),
	.rsp(rsp)
);

//--- verification/sym_vn_lut_tb.sv
`timescale 1ns/1ps

module sym_vn_lut_tb;

	localparam int period = 100;
	localparam int tbl_depth = 128;
	localparam int max_tests = 32;
	localparam int n_random = 8;
	localparam int wd_margin = 20;

	logic read_clk;
	logic rst_n;
	logic req_valid;
	logic req_ready;
	vn_lut_pkg::vn_req_t req;
	logic wr_en;
	vn_lut_pkg::lut_wr_t wr;
	logic rsp_valid;
	logic rsp_ready;
	vn_lut_pkg::vn_rsp_t rsp;

	integer seed;
	int cyc;
	int errors;
	int n_tests;
	int n_done;
	int n_fail;

	// Copy of the table as loaded into the DUT
	logic [3:0] mirror0 [tbl_depth];
	logic [3:0] mirror1 [tbl_depth];

	////////////////////////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////////////////////////

	string t_name [max_tests];
	vn_lut_pkg::vn_req_t t_req [max_tests];
	logic [7:0] t_stall [max_tests];
	bit t_lat [max_tests];
	bit t_same [max_tests];

	// Accepted requests still waiting for their response
	int exp_q [$];
	int acc_cyc [$];

	sym_vn_lut_top dut (
		.read_clk(read_clk),
		.rst_n(rst_n),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req(req),
		.wr_en(wr_en),
		.wr(wr),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.rsp(rsp)
	);

	always #(period / 2) read_clk = ~read_clk;

	always @(posedge read_clk) begin
		cyc <= cyc + 1;
	end

	// Port fields are {y0, y1, transpose_en}
	task automatic add_test(input string name, input logic [8:0] a, input logic [8:0] b,
		input logic off, input logic [7:0] stall, input bit lat, input bit same);
		t_name[n_tests] = name;
		t_req[n_tests] = {a, b, off};
		t_stall[n_tests] = stall;
		t_lat[n_tests] = lat;
		t_same[n_tests] = same;
		n_tests++;
	endtask

	task automatic build_table();
		logic [31:0] rnd;
		add_test("pos_bank0", {4'h1, 4'h3, 1'b0}, {4'h2, 4'h5, 1'b0}, 1'b0, 8'hff, 1, 0);
		add_test("pos_bank1", {4'h6, 4'hc, 1'b0}, {4'h7, 4'h7, 1'b0}, 1'b0, 8'hff, 1, 0);
		add_test("neg_y0", {4'h9, 4'h3, 1'b0}, {4'he, 4'ha, 1'b0}, 1'b0, 8'hff, 1, 0);
		add_test("sign_pair", {4'h1, 4'h3, 1'b0}, {4'he, 4'hc, 1'b0}, 1'b0, 8'hff, 1, 1);
		add_test("transpose", {4'h2, 4'h6, 1'b1}, {4'ha, 4'h6, 1'b1}, 1'b0, 8'hff, 1, 0);
		add_test("mixed_ports", {4'h3, 4'h9, 1'b0}, {4'hc, 4'h1, 1'b1}, 1'b0, 8'hff, 1, 0);
		add_test("offset_pos", {4'h4, 4'h2, 1'b0}, {4'h0, 4'hf, 1'b0}, 1'b1, 8'hff, 1, 0);
		add_test("offset_neg", {4'hb, 4'h5, 1'b1}, {4'h8, 4'h0, 1'b0}, 1'b1, 8'hff, 1, 0);
		// Bit 0 of the stall mask set so a stalled response still drains
		for (int k = 0; k < n_random; k++) begin
			rnd = $random(seed);
			add_test($sformatf("rand_%0d", k), rnd[8:0], rnd[17:9], rnd[18],
				{rnd[26:20], 1'b1}, 0, 0);
		end
	endtask

	task automatic load_table();
		logic [31:0] rnd;
		for (int i = 0; i < tbl_depth; i++) begin
			rnd = $random(seed);
			mirror0[i] = rnd[3:0];
			mirror1[i] = rnd[7:4];
			wr.offset = i[6];
			wr.page = i[5:0];
			wr.data_bank0 = rnd[3:0];
			wr.data_bank1 = rnd[7:4];
			wr_en = 1'b1;
			@(posedge read_clk);
			#1;
		end
		wr_en = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic logic [3:0] lookup(input vn_lut_pkg::vn_port_req_t p, input logic off);
		logic msb;
		logic [2:0] mag;
		logic [3:0] y1f;
		logic [6:0] idx;
		msb = p.y0[3] ^ p.transpose_en;
		// Negative codes count down from the top of the magnitude range
		mag = p.y0[3] ? 3'd7 - p.y0[2:0] : p.y0[2:0];
		y1f = msb ? 4'd15 - p.y1 : p.y1;
		idx = {off, mag[1:0], y1f};
		if (mag[2]) begin
			return mirror1[idx];
		end
		return mirror0[idx];
	endfunction

	function automatic vn_lut_pkg::vn_rsp_t model(input vn_lut_pkg::vn_req_t r);
		vn_lut_pkg::vn_rsp_t m;
		m.t_c_a = lookup(r.port_a, r.offset);
		m.t_c_b = lookup(r.port_b, r.offset);
		m.transpose_en_a = r.port_a.y0[3] ^ r.port_a.transpose_en;
		m.transpose_en_b = r.port_b.y0[3] ^ r.port_b.transpose_en;
		m.offset = r.offset;
		return m;
	endfunction

	task automatic check_rsp();
		int idx;
		int lat;
		bit ok;
		vn_lut_pkg::vn_rsp_t want;
		assert (exp_q.size() != 0) else begin
			$display("Response arrived with no request outstanding");
			errors++;
		end
		if (exp_q.size() != 0) begin
			idx = exp_q.pop_front();
			lat = cyc - acc_cyc.pop_front();
			want = model(t_req[idx]);
			ok = 1;
			assert (rsp == want) else begin
				$display("[ERROR] %s expected %h actual %h", t_name[idx], want, rsp);
				ok = 0;
			end
			if (t_lat[idx]) begin
				assert (lat == 2) else begin
					$display("Test %s answered %0d cycles after acceptance, not 2",
						t_name[idx], lat);
					ok = 0;
				end
			end
			if (t_same[idx]) begin
				assert (rsp.t_c_a == rsp.t_c_b) else begin
					$display("[ERROR] %s expected %h actual %h", t_name[idx],
						rsp.t_c_a, rsp.t_c_b);
					ok = 0;
				end
			end
			if (!ok) begin
				n_fail++;
			end
			n_done++;
			$display("test %s %s", t_name[idx], ok ? "pass" : "fail");
		end
	endtask

	////////////////////////////////////////////////////////////
	// Processes
	////////////////////////////////////////////////////////////

	// Transfer happens at the next rising edge
	initial begin : sink
		forever begin
			@(negedge read_clk);
			if (rsp_valid && rsp_ready) begin
				check_rsp();
			end
		end
	end

	// Back-pressure follows the stall mask of the oldest request
	initial begin : ready_drive
		logic [2:0] phase;
		forever begin
			@(posedge read_clk);
			#1;
			phase = cyc[2:0];
			if (exp_q.size() == 0) begin
				rsp_ready = 1'b1;
			end else begin
				rsp_ready = t_stall[exp_q[0]][phase];
			end
		end
	end

	initial begin : watchdog
		#1;
		#(period * (n_tests * 20 + tbl_depth + wd_margin));
		$display("Watchdog expired before all responses arrived");
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin : main
		seed = 32'hf603;
		cyc = 0;
		errors = 0;
		n_tests = 0;
		n_done = 0;
		n_fail = 0;
		read_clk = 1'b0;
		rst_n = 1'b0;
		req_valid = 1'b0;
		req = '0;
		wr_en = 1'b0;
		wr = '0;
		rsp_ready = 1'b1;
		build_table();
		repeat (3) @(posedge read_clk);
		#1;
		rst_n = 1'b1;
		assert (!rsp_valid && req_ready) else begin
			$display("Pipeline not idle after reset");
			errors++;
		end
		load_table();
		for (int i = 0; i < n_tests; i++) begin
			req = t_req[i];
			req_valid = 1'b1;
			@(negedge read_clk);
			while (!req_ready) begin
				@(negedge read_clk);
			end
			exp_q.push_back(i);
			acc_cyc.push_back(cyc);
			@(posedge read_clk);
			#1;
		end
		req_valid = 1'b0;
		while (exp_q.size() != 0) begin
			@(posedge read_clk);
		end
		repeat (4) @(posedge read_clk);
		$display("tests %0d, passed %0d, failed %0d, other errors %0d",
			n_tests, n_done - n_fail, n_fail, errors);
		if (errors == 0 && n_fail == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- verilog.f
hw/vn_lut_pkg.sv
hw/pipe_stage.sv
hw/vn_input_fold.sv
hw/vn_lut_bank.sv
hw/sym_vn_lut_top.sv
verification/sym_vn_lut_props.sv
verification/sym_vn_lut_tb.sv
